//--- verilog/dsp_pkg.sv
/*
 * Shared widths, register addresses, address target enum
 * and the 16/15-bit saturation functions of the mixer
 */
`default_nettype none

package dsp_pkg;

    localparam int VOICE_PCM_W = 15;  // Voice sample and scaled voice
    localparam int MIX_W       = 16;  // Bus and output sample
    localparam int VOL_W       = 8;   // All volume registers, signed
    localparam int ADDR_W      = 7;
    localparam int MAX_VOICES  = 8;
    localparam int SAT_IN_W    = 32;  // Widest value the clamps accept

    // ------------------------------
    // Register map
    // ------------------------------
    localparam logic [3:0] REG_VOL_L = 4'h0;  // Low nibble, per voice
    localparam logic [3:0] REG_VOL_R = 4'h1;

    localparam logic [ADDR_W-1:0] ADDR_MVOL_L = 7'h0c;
    localparam logic [ADDR_W-1:0] ADDR_MVOL_R = 7'h1c;
    localparam logic [ADDR_W-1:0] ADDR_FLG    = 7'h6c;
    localparam logic [ADDR_W-1:0] ADDR_UNUSED = 7'h1d;
    localparam logic [ADDR_W-1:0] ADDR_EON    = 7'h4d;

    localparam logic [7:0] FLG_RESET    = 8'he0;  // Reset, mute and echo-off set
    localparam int         FLG_MUTE_BIT = 6;

    typedef enum logic [2:0] {
        DT_VOL_L_X,
        DT_VOL_R_X,
        DT_MVOL_L,
        DT_MVOL_R,
        DT_FLG,
        DT_UNUSED,
        DT_EON,
        DT_NONE
    } dsp_target_t;

    // ------------------------------
    // Saturation
    // ------------------------------
    function automatic logic signed [MIX_W-1:0] sat16(input logic signed [SAT_IN_W-1:0] v);
        if (v > 32'sh7fff) begin
            sat16 = 16'sh7fff;
        end else if (v < -32'sh8000) begin
            sat16 = 16'sh8000;
        end else begin
            sat16 = v[MIX_W-1:0];
        end
    endfunction

    function automatic logic signed [VOICE_PCM_W-1:0] sat15(
        input logic signed [SAT_IN_W-1:0] v
    );
        if (v > 32'sh3fff) begin
            sat15 = 15'sh3fff;
        end else if (v < -32'sh4000) begin
            sat15 = 15'sh4000;
        end else begin
            sat15 = v[VOICE_PCM_W-1:0];
        end
    endfunction

endpackage

`default_nettype wire

//--- verilog/dsp_reg_if.sv
/*
 * Register values from the register file to the
 * voice, mix and master stages
 */
`timescale 1ns/1ps
`default_nettype none

interface dsp_reg_if
    import dsp_pkg::*;
#(
    parameter int NUM_VOICES = 8
) ();

    logic signed [VOL_W-1:0] vol_l [NUM_VOICES];  // Per-voice volume
    logic signed [VOL_W-1:0] vol_r [NUM_VOICES];
    logic signed [VOL_W-1:0] mvol_l;              // Main volume
    logic signed [VOL_W-1:0] mvol_r;
    logic                    mute;                // FLG bit 6
    logic [NUM_VOICES-1:0]   echo_en;             // EON, one bit per voice

    modport regs (
        output vol_l, vol_r, mvol_l, mvol_r, mute, echo_en
    );

    modport voice (input vol_l, vol_r);

    modport mix (input echo_en);

    modport master (input mvol_l, mvol_r, mute);

endinterface

`default_nettype wire

//--- verilog/dsp_regs.sv
/*
 * Host register file: address decode, storage of the
 * kept registers and the combinational read mux
 */
`timescale 1ns/1ps
`default_nettype none

module dsp_regs
    import dsp_pkg::*;
#(
    parameter int NUM_VOICES = 8
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [ADDR_W-1:0] reg_addr,
    input  logic [7:0]        reg_wdata,
    input  logic              reg_write,
    output logic [7:0]        reg_rdata,
    dsp_reg_if.regs           regs
);

    localparam int VIDX_W = $clog2(MAX_VOICES);

    dsp_target_t       target;
    logic [VIDX_W-1:0] ch;  // Voice select, upper address bits

    logic signed [VOL_W-1:0] vol_l_q [NUM_VOICES];
    logic signed [VOL_W-1:0] vol_r_q [NUM_VOICES];
    logic signed [VOL_W-1:0] mvol_l_q;
    logic signed [VOL_W-1:0] mvol_r_q;
    logic [7:0]              flg_q;
    logic [7:0]              unused_q;  // Plain R/W byte at 0x1D
    logic [7:0]              eon_q;

    // ------------------------------
    // Address decode
    // ------------------------------
    assign ch = reg_addr[ADDR_W-1 -: VIDX_W];

    always_comb begin
        target = DT_NONE;
        case (reg_addr)
            ADDR_MVOL_L: target = DT_MVOL_L;
            ADDR_MVOL_R: target = DT_MVOL_R;
            ADDR_FLG:    target = DT_FLG;
            ADDR_UNUSED: target = DT_UNUSED;
            ADDR_EON:    target = DT_EON;
            default: begin
                // Voices beyond NUM_VOICES stay DT_NONE
                if (int'(ch) < NUM_VOICES) begin
                    if (reg_addr[3:0] == REG_VOL_L) begin
                        target = DT_VOL_L_X;
                    end else if (reg_addr[3:0] == REG_VOL_R) begin
                        target = DT_VOL_R_X;
                    end
                end
            end
        endcase
    end

    // ------------------------------
    // Storage
    // ------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                vol_l_q[i] <= '0;
                vol_r_q[i] <= '0;
            end
            mvol_l_q <= '0;
            mvol_r_q <= '0;
            flg_q    <= FLG_RESET;
            unused_q <= '0;
            eon_q    <= '0;
        end else if (reg_write) begin
            case (target)
                DT_VOL_L_X: vol_l_q[ch] <= reg_wdata;
                DT_VOL_R_X: vol_r_q[ch] <= reg_wdata;
                DT_MVOL_L:  mvol_l_q    <= reg_wdata;
                DT_MVOL_R:  mvol_r_q    <= reg_wdata;
                DT_FLG:     flg_q       <= reg_wdata;
                DT_UNUSED:  unused_q    <= reg_wdata;
                DT_EON:     eon_q       <= reg_wdata;
                default: ;  // Dropped addresses ignore writes
            endcase
        end
    end

    // Read mux
    always_comb begin
        case (target)
            DT_VOL_L_X: reg_rdata = vol_l_q[ch];
            DT_VOL_R_X: reg_rdata = vol_r_q[ch];
            DT_MVOL_L:  reg_rdata = mvol_l_q;
            DT_MVOL_R:  reg_rdata = mvol_r_q;
            DT_FLG:     reg_rdata = flg_q;
            DT_UNUSED:  reg_rdata = unused_q;
            DT_EON:     reg_rdata = eon_q;
            default:    reg_rdata = '0;
        endcase
    end

    // To the datapath
    assign regs.vol_l   = vol_l_q;
    assign regs.vol_r   = vol_r_q;
    assign regs.mvol_l  = mvol_l_q;
    assign regs.mvol_r  = mvol_r_q;
    assign regs.mute    = flg_q[FLG_MUTE_BIT];
    assign regs.echo_en = eon_q[NUM_VOICES-1:0];

endmodule

`default_nettype wire

//--- verilog/voice_volume.sv
/*
 * Stage 1: per-voice signed volume scaling, left and right
 */
`timescale 1ns/1ps
`default_nettype none

module voice_volume
    import dsp_pkg::*;
#(
    parameter int NUM_VOICES = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic signed [VOICE_PCM_W-1:0] voice_pcm [NUM_VOICES],
    dsp_reg_if.voice                      regs,
    output logic signed [VOICE_PCM_W-1:0] chsound_l [NUM_VOICES],
    output logic signed [VOICE_PCM_W-1:0] chsound_r [NUM_VOICES]
);

    localparam int PROD_W = VOICE_PCM_W + VOL_W;

    logic signed [PROD_W-1:0] prod_l [NUM_VOICES];
    logic signed [PROD_W-1:0] prod_r [NUM_VOICES];

    always_comb begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            prod_l[i] = voice_pcm[i] * regs.vol_l[i];
            prod_r[i] = voice_pcm[i] * regs.vol_r[i];
        end
    end

    // Volume 0x7F is just under unity, hence the shift by 7
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                chsound_l[i] <= '0;
                chsound_r[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_VOICES; i++) begin
                chsound_l[i] <= sat15(prod_l[i] >>> 7);
                chsound_r[i] <= sat15(prod_r[i] >>> 7);
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/mix_bus.sv
/*
 * Stage 2: sums the audible voices into the main bus and
 * the echo-send bus, each saturated to 16 bits
 */
`timescale 1ns/1ps
`default_nettype none

module mix_bus
    import dsp_pkg::*;
#(
    parameter int NUM_VOICES = 8
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic signed [VOICE_PCM_W-1:0] chsound_l [NUM_VOICES],
    input  logic signed [VOICE_PCM_W-1:0] chsound_r [NUM_VOICES],
    input  logic [NUM_VOICES-1:0]         sound_off,
    dsp_reg_if.mix                        regs,
    output logic signed [MIX_W-1:0]       sum_l,
    output logic signed [MIX_W-1:0]       sum_r,
    output logic signed [MIX_W-1:0]       echo_l,
    output logic signed [MIX_W-1:0]       echo_r
);

    localparam int SUM_W = MIX_W + 2;  // 8 x 0x3FFF plus sign

    logic signed [SUM_W-1:0] main_l_raw, main_r_raw;
    logic signed [SUM_W-1:0] echo_l_raw, echo_r_raw;

    // ------------------------------
    // Masked sums
    // ------------------------------
    always_comb begin
        main_l_raw = '0;
        main_r_raw = '0;
        echo_l_raw = '0;
        echo_r_raw = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (!sound_off[i]) begin
                main_l_raw += chsound_l[i];
                main_r_raw += chsound_r[i];
                if (regs.echo_en[i]) begin  // Echo send only for EON voices
                    echo_l_raw += chsound_l[i];
                    echo_r_raw += chsound_r[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_l  <= '0;
            sum_r  <= '0;
            echo_l <= '0;
            echo_r <= '0;
        end else begin
            sum_l  <= sat16(main_l_raw);
            sum_r  <= sat16(main_r_raw);
            echo_l <= sat16(echo_l_raw);
            echo_r <= sat16(echo_r_raw);
        end
    end

endmodule

`default_nettype wire

//--- verilog/master_out.sv
/*
 * Stage 3: main volume, saturation and FLG mute
 */
`timescale 1ns/1ps
`default_nettype none

module master_out
    import dsp_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic signed [MIX_W-1:0] sum_l,
    input  logic signed [MIX_W-1:0] sum_r,
    dsp_reg_if.master               regs,
    output logic signed [MIX_W-1:0] sound_l,
    output logic signed [MIX_W-1:0] sound_r
);

    localparam int PROD_W = MIX_W + VOL_W;

    logic signed [PROD_W-1:0] prod_l, prod_r;

    assign prod_l = sum_l * regs.mvol_l;
    assign prod_r = sum_r * regs.mvol_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            sound_l <= '0;
            sound_r <= '0;
        end else if (regs.mute) begin
            sound_l <= '0;  // Mute only silences the main output
            sound_r <= '0;
        end else begin
            sound_l <= sat16(prod_l >>> 7);
            sound_r <= sat16(prod_r >>> 7);
        end
    end

endmodule

`default_nettype wire

//--- verilog/dsp_mixer.sv
/*
 * Mixer top level: register file and the three-stage
 * voice, mix and master pipeline
 */
`timescale 1ns/1ps
`default_nettype none

module dsp_mixer
    import dsp_pkg::*;
#(
    parameter int NUM_VOICES = 8
) (
    input  logic                          clk,
    input  logic                          reset,

    // Host register port
    input  logic [ADDR_W-1:0]             reg_addr,
    input  logic [7:0]                    reg_wdata,
    input  logic                          reg_write,
    output logic [7:0]                    reg_rdata,

    input  logic signed [VOICE_PCM_W-1:0] voice_pcm [NUM_VOICES],
    input  logic [NUM_VOICES-1:0]         sound_off,

    output logic signed [MIX_W-1:0]       sound_l,
    output logic signed [MIX_W-1:0]       sound_r,
    output logic signed [MIX_W-1:0]       sound_echo_l,  // To external echo unit
    output logic signed [MIX_W-1:0]       sound_echo_r
);

    logic signed [VOICE_PCM_W-1:0] chsound_l [NUM_VOICES];
    logic signed [VOICE_PCM_W-1:0] chsound_r [NUM_VOICES];
    logic signed [MIX_W-1:0]       sum_l, sum_r;

    dsp_reg_if #(.NUM_VOICES(NUM_VOICES)) regs_if ();

    // ------------------------------
    // Register file
    // ------------------------------
    dsp_regs #(.NUM_VOICES(NUM_VOICES)) dsp_regs_i (
        .clk,
        .reset,
        .reg_addr,
        .reg_wdata,
        .reg_write,
        .reg_rdata,
        .regs(regs_if.regs)
    );

    // ------------------------------
    // Pipeline
    // ------------------------------
    voice_volume #(.NUM_VOICES(NUM_VOICES)) voice_volume_i (
        .clk,
        .reset,
        .voice_pcm,
        .regs(regs_if.voice),
        .chsound_l,
        .chsound_r
    );

    mix_bus #(.NUM_VOICES(NUM_VOICES)) mix_bus_i (
        .clk,
        .reset,
        .chsound_l,
        .chsound_r,
        .sound_off,
        .regs(regs_if.mix),
        .sum_l,
        .sum_r,
        .echo_l(sound_echo_l),
        .echo_r(sound_echo_r)
    );

    master_out master_out_i (
        .clk,
        .reset,
        .sum_l,
        .sum_r,
        .regs(regs_if.master),
        .sound_l,
        .sound_r
    );

endmodule

`default_nettype wire

//--- bench/tb_dsp_mixer.sv
/*
 * Testbench for the mixer: clock, reset, register and audio
 * stimulus, reference model, assertions and reporting
 */
`timescale 1ns/1ps
`default_nettype none

module tb_dsp_mixer;

    localparam int CYCLE_LIMIT = 2000;  // About 300 cycles of tests, wide margin

    logic              clk;
    logic              reset;
    logic [6:0]        reg_addr;
    logic [7:0]        reg_wdata;
    logic              reg_write;
    logic [7:0]        reg_rdata;
    logic signed [14:0] voice_pcm [8];
    logic [7:0]        sound_off;
    logic signed [15:0] sound_l, sound_r, sound_echo_l, sound_echo_r;

    logic [7:0] shadow [128];  // Expected register contents
    int seed = 95863;
    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int failed_tests = 0;
    int errors_at_start;

    dsp_mixer #(.NUM_VOICES(8)) dsp_mixer_i (
        .clk, .reset, .reg_addr, .reg_wdata, .reg_write, .reg_rdata,
        .voice_pcm, .sound_off, .sound_l, .sound_r, .sound_echo_l, .sound_echo_r
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic bit is_kept(input logic [6:0] addr);
        if (addr[3:0] == 4'h0 || addr[3:0] == 4'h1) begin
            return 1'b1;  // VOL_L / VOL_R of every voice
        end
        return addr == 7'h0c || addr == 7'h1c || addr == 7'h6c ||
               addr == 7'h1d || addr == 7'h4d;
    endfunction

    function automatic int clamp(input int v, input int lo, input int hi);
        return (v < lo) ? lo : ((v > hi) ? hi : v);
    endfunction

    task automatic model_outputs(output int ml, output int mr, output int el, output int er);
        int vl, vr, acc_l, acc_r, acc_el, acc_er;
        acc_l = 0;
        acc_r = 0;
        acc_el = 0;
        acc_er = 0;
        for (int v = 0; v < 8; v++) begin
            vl = clamp((int'(voice_pcm[v]) * int'($signed(shadow[v * 16]))) >>> 7,
                       -16384, 16383);
            vr = clamp((int'(voice_pcm[v]) * int'($signed(shadow[v * 16 + 1]))) >>> 7,
                       -16384, 16383);
            if (!sound_off[v]) begin
                acc_l += vl;
                acc_r += vr;
                if (shadow[7'h4d][v]) begin
                    acc_el += vl;
                    acc_er += vr;
                end
            end
        end
        el = clamp(acc_el, -32768, 32767);
        er = clamp(acc_er, -32768, 32767);
        acc_l = clamp(acc_l, -32768, 32767);
        acc_r = clamp(acc_r, -32768, 32767);
        if (shadow[7'h6c][6]) begin  // Mute
            ml = 0;
            mr = 0;
        end else begin
            ml = clamp((acc_l * int'($signed(shadow[7'h0c]))) >>> 7, -32768, 32767);
            mr = clamp((acc_r * int'($signed(shadow[7'h1c]))) >>> 7, -32768, 32767);
        end
    endtask

    // ------------------------------
    // Checks and stimulus
    // ------------------------------
    task automatic expect_eq(input int got, input int exp, input string what);
        checks++;
        assert (got == exp) else begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs(input string tag);
        int ml, mr, el, er;
        model_outputs(ml, mr, el, er);
        expect_eq(sound_l, ml, {tag, " sound_l"});
        expect_eq(sound_r, mr, {tag, " sound_r"});
        expect_eq(sound_echo_l, el, {tag, " sound_echo_l"});
        expect_eq(sound_echo_r, er, {tag, " sound_echo_r"});
    endtask

    // Called right after a falling edge, returns right after one
    task automatic write_reg(input logic [6:0] addr, input logic [7:0] data);
        reg_addr = addr;
        reg_wdata = data;
        reg_write = 1'b1;
        if (is_kept(addr)) begin
            shadow[addr] = data;
        end
        @(negedge clk);
        reg_write = 1'b0;
    endtask

    task automatic check_read(input logic [6:0] addr);
        logic [7:0] exp;
        exp = is_kept(addr) ? shadow[addr] : 8'h00;
        reg_addr = addr;
        @(negedge clk);
        expect_eq(reg_rdata, exp, $sformatf("read of 0x%02h", addr));
    endtask

    task automatic set_all_vol(input logic [7:0] value);
        for (int v = 0; v < 8; v++) begin
            write_reg(7'(v * 16), value);
            write_reg(7'(v * 16 + 1), value);
        end
    endtask

    task automatic set_all_pcm(input logic signed [14:0] value);
        for (int v = 0; v < 8; v++) begin
            voice_pcm[v] = value;
        end
    endtask

    task automatic settle_and_check(input string tag);
        repeat (4) @(negedge clk);
        check_outputs(tag);
    endtask

    task automatic start_test;
        errors_at_start = errors;
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        int ml_old, mr_old, el_old, er_old;
        int ml_new, mr_new, el_new, er_new;
        reset = 1'b1;
        reg_addr = '0;
        reg_wdata = '0;
        reg_write = 1'b0;
        sound_off = '0;
        set_all_pcm('0);
        for (int a = 0; a < 128; a++) begin
            shadow[a] = 8'h00;
        end
        shadow[7'h6c] = 8'he0;  // FLG reset value
        repeat (4) @(negedge clk);
        reset = 1'b0;

        start_test();
        for (int a = 0; a < 128; a++) begin
            if (is_kept(7'(a))) begin
                check_read(7'(a));
            end
        end
        check_outputs("reset");
        report_test("reset values");

        start_test();
        for (int a = 0; a < 128; a++) begin
            if (is_kept(7'(a))) begin
                write_reg(7'(a), 8'($random(seed)));
            end
        end
        for (int a = 0; a < 128; a++) begin
            if (is_kept(7'(a))) begin
                check_read(7'(a));
            end
        end
        write_reg(7'h7c, 8'hff);  // Dropped addresses
        write_reg(7'h5d, 8'hff);
        check_read(7'h7c);
        check_read(7'h5d);
        report_test("register round trip");

        start_test();
        write_reg(7'h6c, 8'h00);
        for (int it = 0; it < 6; it++) begin
            for (int v = 0; v < 8; v++) begin
                write_reg(7'(v * 16), 8'($random(seed)));
                write_reg(7'(v * 16 + 1), 8'($random(seed)));
                voice_pcm[v] = 15'($random(seed));
            end
            write_reg(7'h0c, 8'($random(seed)));
            write_reg(7'h1c, 8'($random(seed)));
            write_reg(7'h4d, 8'($random(seed)));
            sound_off = 8'($random(seed));
            settle_and_check($sformatf("mix %0d", it));
        end
        report_test("random mixing");

        start_test();
        sound_off = 8'h00;
        set_all_vol(8'h7f);
        write_reg(7'h0c, 8'h7f);
        write_reg(7'h1c, 8'h7f);
        write_reg(7'h4d, 8'hff);
        set_all_pcm(15'sh3fff);
        settle_and_check("positive full scale");
        expect_eq(sound_echo_l, 32767, "echo clamp high");
        set_all_pcm(15'sh4000);
        settle_and_check("negative full scale");
        expect_eq(sound_echo_r, -32768, "echo clamp low");
        write_reg(7'h0c, 8'h80);  // Most negative main volume on a clamped bus
        settle_and_check("main volume clamp");
        expect_eq(sound_l, 32767, "main clamp high");
        write_reg(7'h00, 8'h80);  // Lone voice 0 at -16384 times -128
        sound_off = 8'hfe;
        settle_and_check("voice clamp");
        expect_eq(sound_echo_l, 16383, "voice clamp high");
        sound_off = 8'h00;
        report_test("saturation");

        start_test();
        set_all_pcm(15'sh3fff);
        write_reg(7'h6c, 8'h40);
        settle_and_check("mute");
        expect_eq(sound_l, 0, "muted sound_l");
        expect_eq(sound_echo_l != 0, 1, "echo alive under mute");
        report_test("mute");

        start_test();
        write_reg(7'h6c, 8'h00);
        set_all_vol(8'h40);
        write_reg(7'h0c, 8'h40);
        set_all_pcm('0);
        settle_and_check("latency base");
        model_outputs(ml_old, mr_old, el_old, er_old);
        for (int v = 0; v < 8; v++) begin
            voice_pcm[v] = 15'(1000 * (v + 1));
        end
        model_outputs(ml_new, mr_new, el_new, er_new);
        @(negedge clk);
        expect_eq(sound_echo_l, el_old, "echo after 1 cycle");
        @(negedge clk);
        expect_eq(sound_echo_l, el_new, "echo after 2 cycles");
        expect_eq(sound_l, ml_old, "sound_l after 2 cycles");
        @(negedge clk);
        expect_eq(sound_l, ml_new, "sound_l after 3 cycles");
        report_test("pipeline latency");

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
verilog/dsp_pkg.sv
verilog/dsp_reg_if.sv
verilog/dsp_regs.sv
verilog/voice_volume.sv
verilog/mix_bus.sv
verilog/master_out.sv
verilog/dsp_mixer.sv
bench/tb_dsp_mixer.sv

//--- Makefile
# Verilator simulation of the mixer testbench
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dsp_mixer \
		-f list.f -o tb_dsp_mixer
	./obj_dir/tb_dsp_mixer | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
